/* compile.f */
source/opl_pkg.sv
source/reg_wr_if.sv
source/reg_write_port.sv
source/opl_reg_file.sv
source/slot_sequencer.sv
source/level_operator.sv
source/modulation_mem.sv
source/opl_op_ctrl_top.sv
verification/tb_assertions.sv
verification/tb_top.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf build
mkdir -p build
verilator --binary --timing --assert -j 0 \
    -f compile.f --top-module tb_top -Mdir build/obj -o Vtb_top

status=0
./build/obj/Vtb_top +verilator+error+limit+100 > build/sim.log 2>&1 || status=$?
cat build/sim.log

if grep -qx "sim passed" build/sim.log; then
    exit 0
fi
echo "simulation did not pass, exit status $status"
exit 1

/* verification/tb_top.sv */
// drives inputs on the falling edge and writes registers only while no frame is running
`timescale 1ns/1ps

module tb_top;
    localparam int num_frames     = 7;
    localparam int frame_cycles   = 50;
    localparam int num_writes     = 120;
    localparam int write_cycles   = 8;
    localparam int timeout_cycles = num_frames * frame_cycles + num_writes * write_cycles + 100;

    logic               clk;
    logic               arst_n;
    logic               sample_clk_en;
    logic [5:0]         connection_sel;
    logic               wr_req;
    opl_pkg::bank_t     wr_bank;
    opl_pkg::reg_addr_t wr_addr;
    opl_pkg::reg_data_t wr_data;
    logic               wr_ack;
    logic               op_valid;
    opl_pkg::bank_t     op_bank;
    opl_pkg::op_num_t   op_num;
    opl_pkg::op_out_t   op_out;
    logic               ops_done;

    opl_pkg::tl_t     tl_shadow  [opl_pkg::num_banks][opl_pkg::ops_per_bank]; // by operator
    logic             kon_shadow [opl_pkg::num_banks][opl_pkg::chan_depth];
    logic             cnt_shadow [opl_pkg::num_banks][opl_pkg::chan_depth];
    opl_pkg::op_out_t prev_out   [opl_pkg::num_banks][opl_pkg::ops_per_bank]; // last frame
    integer           seed = 32'heff6;
    string            test_name = "startup";
    int               cycle_cnt = 0;

    opl_op_ctrl_top UUT (
        .clk, .arst_n, .sample_clk_en, .connection_sel, .wr_req, .wr_bank, .wr_addr,
        .wr_data, .wr_ack, .op_valid, .op_bank, .op_num, .op_out, .ops_done
    );

    initial clk = 1'b0;
    always #2 clk = ~clk; // 4 ns period

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            $display("run exceeded %0d cycles during %s", timeout_cycles, test_name);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic compare_result(input string name, input opl_pkg::op_out_t exp,
                                  input opl_pkg::op_out_t act);
        if (act !== exp) begin
            $display("ERR %s expected %0d actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic expect_tag(input string name, input opl_pkg::bank_t exp_bank,
                              input opl_pkg::op_num_t exp_op, input opl_pkg::bank_t act_bank,
                              input opl_pkg::op_num_t act_op);
        if (act_bank !== exp_bank || act_op !== exp_op) begin
            $display("ERR %s expected bank %0d op %0d actual bank %0d op %0d",
                     name, exp_bank, exp_op, act_bank, act_op);
            abort_run();
        end
    endtask

    task automatic match_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("ERR %s expected %b actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic clear_model();
        for (int b = 0; b < opl_pkg::num_banks; b++) begin
            for (int n = 0; n < opl_pkg::ops_per_bank; n++) begin
                tl_shadow[b][n] = '0;
                prev_out[b][n]  = '0;
            end
            for (int c = 0; c < opl_pkg::chan_depth; c++) begin
                kon_shadow[b][c] = 1'b0;
                cnt_shadow[b][c] = 1'b0;
            end
        end
    endtask

    task automatic wait_ack(input logic level);
        int wait_cnt;
        wait_cnt = 0;
        while (wr_ack !== level) begin
            if (wait_cnt == write_cycles) begin
                $display("wr_ack did not reach %b for address 0x%02h", level, wr_addr);
                abort_run();
            end
            @(negedge clk);
            wait_cnt++;
        end
    endtask

    // full four-phase write, returns once wr_ack is low again
    task automatic write_reg(input opl_pkg::bank_t bank, input opl_pkg::reg_addr_t addr,
                             input opl_pkg::reg_data_t data);
        @(negedge clk);
        wr_bank = bank;
        wr_addr = addr;
        wr_data = data;
        wr_req  = 1'b1;
        wait_ack(1'b1);
        wr_req = 1'b0;
        wait_ack(1'b0);
    endtask

    task automatic program_tl(input int b, input int n, input opl_pkg::tl_t v);
        int off;
        off = (n < 6) ? n : (n < 12) ? n + 2 : n + 4; // register map skips two gaps
        write_reg(opl_pkg::bank_t'(b), opl_pkg::tl_base + opl_pkg::reg_addr_t'(off),
                  {2'b10, v}); // ksl bits must not leak into tl
        tl_shadow[b][n] = v;
    endtask

    task automatic key_on_chan(input int b, input int ch, input logic v);
        write_reg(opl_pkg::bank_t'(b), opl_pkg::kon_base + opl_pkg::reg_addr_t'(ch),
                  {2'b00, v, 5'b10101}); // block and fnum bits are don't care
        kon_shadow[b][ch] = v;
    endtask

    task automatic write_connection(input int b, input int ch, input logic v);
        write_reg(opl_pkg::bank_t'(b), opl_pkg::cnt_base + opl_pkg::reg_addr_t'(ch),
                  {7'b0000110, v}); // feedback bits ignored
        cnt_shadow[b][ch] = v;
    endtask

    function automatic opl_pkg::op_out_t expected_out(input int b, input int n);
        int   chan;
        int   kon_ch;
        bit   paired;
        bit   elig;
        int   mod;
        int   level;
        chan   = n % 3 + 3 * (n / 6);
        paired = connection_sel[b * 3 + n % 3];
        kon_ch = (n >= 6 && n < 12 && paired) ? n % 3 : chan;
        elig   = ((n / 3) % 2 == 1) || (n / 3 == 2 && paired);
        mod    = 0;
        if (elig && !cnt_shadow[b][chan]) begin
            mod = prev_out[b][n - 3]; // slot three back, previous frame
        end
        level = (63 - tl_shadow[b][n]) * 32 + mod / 2;
        return kon_shadow[b][kon_ch] ? opl_pkg::op_out_t'(level) : '0;
    endfunction

    // one sample_clk_en, then 36 results in slot order and a single ops_done
    task automatic run_frame();
        opl_pkg::op_out_t exp_out [opl_pkg::num_banks][opl_pkg::ops_per_bank];
        int               wait_cnt;
        int               b;
        int               n;
        for (int s = 0; s < opl_pkg::num_banks * opl_pkg::ops_per_bank; s++) begin
            exp_out[s / 18][s % 18] = expected_out(s / 18, s % 18);
        end
        @(negedge clk);
        sample_clk_en = 1'b1;
        @(negedge clk);
        sample_clk_en = 1'b0;
        wait_cnt = 0;
        while (op_valid !== 1'b1) begin
            if (wait_cnt == frame_cycles) begin
                $display("no op_valid after sample_clk_en in %s", test_name);
                abort_run();
            end
            @(negedge clk);
            wait_cnt++;
        end
        for (int s = 0; s < opl_pkg::num_banks * opl_pkg::ops_per_bank; s++) begin
            b = s / 18;
            n = s % 18;
            match_bit(test_name, 1'b1, op_valid);
            expect_tag(test_name, opl_pkg::bank_t'(b), opl_pkg::op_num_t'(n), op_bank, op_num);
            compare_result(test_name, exp_out[b][n], op_out);
            @(negedge clk);
        end
        match_bit(test_name, 1'b0, op_valid);
        match_bit(test_name, 1'b1, ops_done);
        @(negedge clk);
        match_bit(test_name, 1'b0, ops_done);
        prev_out = exp_out;
    endtask

    task automatic test_reset_idle();
        test_name = "test_reset_idle";
        repeat (20) begin
            @(negedge clk);
            match_bit(test_name, 1'b0, wr_ack);
            match_bit(test_name, 1'b0, op_valid);
            match_bit(test_name, 1'b0, ops_done);
        end
    endtask

    task automatic test_reg_handshake();
        test_name = "test_reg_handshake";
        @(negedge clk);
        wr_bank = 1'b0;
        wr_addr = opl_pkg::tl_base;
        wr_data = 8'h55; // ksl 01 with tl 0x15
        wr_req  = 1'b1;
        wait_ack(1'b1);
        repeat (3) begin
            @(negedge clk);
            match_bit(test_name, 1'b1, wr_ack); // held while req stays high
        end
        wr_req = 1'b0;
        @(negedge clk);
        match_bit(test_name, 1'b0, wr_ack);
        tl_shadow[0][0] = 6'h15;
        write_reg(1'b1, 8'h08, 8'hFF); // dropped register
        program_tl(1, 17, 6'h2A);
        program_tl(0, 11, 6'h01);
    endtask

    task automatic test_frame_order();
        test_name = "test_frame_order";
        run_frame();
    endtask

    task automatic test_level_no_mod();
        logic [31:0] rnd;
        test_name = "test_level_no_mod";
        for (int s = 0; s < opl_pkg::num_banks * opl_pkg::ops_per_bank; s++) begin
            rnd = $random(seed);
            program_tl(s / 18, s % 18, rnd[5:0]);
        end
        for (int s = 0; s < opl_pkg::num_banks * opl_pkg::chan_depth; s++) begin
            rnd = $random(seed);
            write_connection(s / 9, s % 9, 1'b1);
            key_on_chan(s / 9, s % 9, rnd[3]);
        end
        run_frame();
        run_frame(); // stored results are nonzero now, cnt must keep them out
    endtask

    task automatic test_modulation_chain();
        test_name = "test_modulation_chain";
        for (int s = 0; s < opl_pkg::num_banks * opl_pkg::chan_depth; s++) begin
            write_connection(s / 9, s % 9, 1'b0);
            key_on_chan(s / 9, s % 9, 1'b1);
        end
        run_frame();
        run_frame();
    endtask

    task automatic test_four_op_pairing();
        test_name = "test_four_op_pairing";
        @(negedge clk);
        connection_sel = 6'b010001; // bank 0 pair 0 and bank 1 pair 1
        key_on_chan(0, 0, 1'b1);
        key_on_chan(0, 3, 1'b0);    // op 6 only sounds through channel 0
        key_on_chan(1, 4, 1'b0);
        run_frame();
        run_frame();
    endtask

    initial begin
        arst_n         = 1'b0;
        sample_clk_en  = 1'b0;
        connection_sel = '0;
        wr_req         = 1'b0;
        wr_bank        = 1'b0;
        wr_addr        = '0;
        wr_data        = '0;
        clear_model();
        repeat (4) @(negedge clk);
        arst_n = 1'b1;

        test_reset_idle();
        test_reg_handshake();
        test_frame_order();
        test_level_no_mod();
        test_modulation_chain();
        test_four_op_pairing();
        repeat (4) @(negedge clk);

        if (UUT.u_checks.failures == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("%0d assertion failures during the run", UUT.u_checks.failures);
            abort_run();
        end
    end
endmodule

/* verification/tb_assertions.sv */
// assumes one outstanding register write at a time and frames of 36 back-to-back slots
`timescale 1ns/1ps

module tb_assertions (
    input logic             clk,
    input logic             arst_n,
    input logic             wr_req,
    input logic             wr_ack,
    input logic             slot_valid,
    input logic             op_valid,
    input opl_pkg::bank_t   op_bank,
    input opl_pkg::op_num_t op_num,
    input logic             ops_done
);
    int failures = 0; // read by the testbench at the end of the run

    ack_rise_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wr_ack) |-> $past(wr_req))
        else begin
            $error("wr_ack rose without a pending wr_req");
            failures = failures + 1;
        end

    ack_fall_after_req: assert property (@(posedge clk) disable iff (!arst_n)
        $fell(wr_ack) |-> !$past(wr_req))
        else begin
            $error("wr_ack fell while wr_req was still high");
            failures = failures + 1;
        end

    issue_to_valid: assert property (@(posedge clk) disable iff (!arst_n)
        slot_valid |-> ##6 op_valid)
        else begin
            $error("op_valid missing six cycles after slot issue");
            failures = failures + 1;
        end

    valid_from_issue: assert property (@(posedge clk) disable iff (!arst_n)
        op_valid |-> $past(slot_valid, 6))
        else begin
            $error("op_valid without a slot issued six cycles earlier");
            failures = failures + 1;
        end

    // single pulse right after bank 1 operator 17
    done_after_last_slot: assert property (@(posedge clk) disable iff (!arst_n)
        ops_done |-> $past(op_valid) && ($past(op_bank) == 1'b1) && ($past(op_num) == 5'd17))
        else begin
            $error("ops_done not directly after the last slot of a frame");
            failures = failures + 1;
        end
endmodule

bind opl_op_ctrl_top tb_assertions u_checks (
    .clk, .arst_n, .wr_req, .wr_ack, .slot_valid, .op_valid, .op_bank, .op_num, .ops_done
);

/* source/opl_op_ctrl_top.sv */
// register writes must be made between frames because the operator pipeline has no back-pressure
`timescale 1ns/1ps

module opl_op_ctrl_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                sample_clk_en,
    input  logic [5:0]          connection_sel,  // four-op pairing, bank 0 in bits 2:0
    input  logic                wr_req,
    input  opl_pkg::bank_t      wr_bank,
    input  opl_pkg::reg_addr_t  wr_addr,
    input  opl_pkg::reg_data_t  wr_data,
    output logic                wr_ack,
    output logic                op_valid,
    output opl_pkg::bank_t      op_bank,
    output opl_pkg::op_num_t    op_num,
    output opl_pkg::op_out_t    op_out,
    output logic                ops_done
);
    logic                 slot_valid;
    opl_pkg::bank_t       slot_bank;
    opl_pkg::op_num_t     slot_op;
    opl_pkg::op_addr_t    op_addr;
    opl_pkg::chan_addr_t  kon_chan;
    opl_pkg::chan_addr_t  cnt_chan;
    logic                 mod_eligible;
    opl_pkg::tl_t         tl;
    logic                 kon;
    logic                 cnt;
    opl_pkg::op_out_t     modulation;

    reg_wr_if wr_bus ();

    reg_write_port u_reg_write_port (
        .clk, .arst_n, .wr_req, .wr_bank, .wr_addr, .wr_data, .wr_ack,
        .wr (wr_bus.source)
    );

    opl_reg_file u_reg_file (
        .clk, .arst_n,
        .wr       (wr_bus.sink),
        .rd_en    (slot_valid),
        .rd_bank  (slot_bank),
        .op_addr, .kon_chan, .cnt_chan, .tl, .kon, .cnt
    );

    slot_sequencer u_slot_sequencer (
        .clk, .arst_n, .sample_clk_en, .connection_sel,
        .slot_valid, .slot_bank, .slot_op, .op_addr, .kon_chan, .cnt_chan, .mod_eligible
    );

    level_operator u_level_operator (
        .clk, .arst_n, .slot_valid, .slot_bank, .slot_op, .tl, .kon, .modulation,
        .op_valid, .op_bank, .op_num, .op_out
    );

    modulation_mem u_modulation_mem (
        .clk, .arst_n, .slot_valid, .slot_bank, .slot_op, .mod_eligible, .cnt,
        .op_valid, .op_bank, .op_num, .op_out, .modulation, .ops_done
    );
endmodule

/* source/modulation_mem.sv */
// modulation always comes from the previous frame because slot n - 3 is still in the pipeline
`timescale 1ns/1ps

module modulation_mem (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             slot_valid,
    input  opl_pkg::bank_t   slot_bank,
    input  opl_pkg::op_num_t slot_op,
    input  logic             mod_eligible,
    input  logic             cnt,         // aligned with the registered read
    input  logic             op_valid,
    input  opl_pkg::bank_t   op_bank,
    input  opl_pkg::op_num_t op_num,
    input  opl_pkg::op_out_t op_out,
    output opl_pkg::op_out_t modulation,
    output logic             ops_done
);
    opl_pkg::op_out_t result_mem [opl_pkg::num_banks][opl_pkg::ops_per_bank];
    opl_pkg::op_out_t rd_q;
    opl_pkg::op_num_t rd_op;
    logic             elig_q;
    logic             op_valid_q;

    // low operators have no source, their eligibility is never set
    assign rd_op = (slot_op >= 5'd3) ? slot_op - 5'd3 : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < opl_pkg::num_banks; b++) begin
                for (int i = 0; i < opl_pkg::ops_per_bank; i++) begin
                    result_mem[b][i] <= '0;
                end
            end
        end else if (op_valid) begin
            result_mem[op_bank][op_num] <= op_out;
        end
    end

    always_ff @(posedge clk) begin
        if (slot_valid) begin
            rd_q   <= result_mem[slot_bank][rd_op];
            elig_q <= mod_eligible;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            op_valid_q <= 1'b0;
        end else begin
            op_valid_q <= op_valid;
        end
    end

    assign modulation = (elig_q && !cnt) ? rd_q : '0; // additive connection takes none
    assign ops_done   = op_valid_q && !op_valid;      // falling edge ends the frame
endmodule

/* source/level_operator.sv */
// level-only stand-in for the FM operator with no envelope, phase or waveform
`timescale 1ns/1ps

module level_operator (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             slot_valid,
    input  opl_pkg::bank_t   slot_bank,
    input  opl_pkg::op_num_t slot_op,
    input  opl_pkg::tl_t     tl,          // arrives one cycle after issue
    input  logic             kon,
    input  opl_pkg::op_out_t modulation,
    output logic             op_valid,
    output opl_pkg::bank_t   op_bank,
    output opl_pkg::op_num_t op_num,
    output opl_pkg::op_out_t op_out
);
    logic [opl_pkg::op_pipe_depth:1] valid_p;
    opl_pkg::bank_t                  bank_p [1:opl_pkg::op_pipe_depth];
    opl_pkg::op_num_t                op_p   [1:opl_pkg::op_pipe_depth];
    opl_pkg::op_out_t                out_p  [3:opl_pkg::op_pipe_depth];

    opl_pkg::tl_t     inv_tl;
    opl_pkg::op_out_t level_s2;
    opl_pkg::op_out_t half_mod_s2;
    logic             kon_s2;

    assign inv_tl = 6'd63 - tl;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_p <= '0;
        end else begin
            valid_p <= {valid_p[opl_pkg::op_pipe_depth-1:1], slot_valid};
        end
    end

    always_ff @(posedge clk) begin
        bank_p[1] <= slot_bank;
        op_p[1]   <= slot_op;
        for (int i = 2; i <= opl_pkg::op_pipe_depth; i++) begin
            bank_p[i] <= bank_p[i-1];
            op_p[i]   <= op_p[i-1];
        end

        level_s2    <= opl_pkg::op_out_t'({2'b00, inv_tl, 5'b00000}); // (63 - tl) * 32
        half_mod_s2 <= modulation >>> 1;
        kon_s2      <= kon;

        out_p[3] <= kon_s2 ? level_s2 + half_mod_s2 : '0; // silent when keyed off
        for (int i = 4; i <= opl_pkg::op_pipe_depth; i++) begin
            out_p[i] <= out_p[i-1];
        end
    end

    assign op_valid = valid_p[opl_pkg::op_pipe_depth];
    assign op_bank  = bank_p[opl_pkg::op_pipe_depth];
    assign op_num   = op_p[opl_pkg::op_pipe_depth];
    assign op_out   = out_p[opl_pkg::op_pipe_depth];
endmodule

/* source/slot_sequencer.sv */
// sample_clk_en is ignored while a frame runs so frames never overlap
`timescale 1ns/1ps

module slot_sequencer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                sample_clk_en,
    input  logic [5:0]          connection_sel,
    output logic                slot_valid,
    output opl_pkg::bank_t      slot_bank,
    output opl_pkg::op_num_t    slot_op,
    output opl_pkg::op_addr_t   op_addr,
    output opl_pkg::chan_addr_t kon_chan,
    output opl_pkg::chan_addr_t cnt_chan,
    output logic                mod_eligible
);
    opl_pkg::seq_state_e                         state;
    logic [$clog2(opl_pkg::num_slot_states)-1:0] slot_cnt;

    logic [1:0]          op_mod3;   // position inside a channel group
    logic [1:0]          op_div6;
    logic [2:0]          op_div3;
    logic [2:0]          pair_idx;
    logic                pair_sel;
    logic                is_mid;    // operators 6..11 can join a four-op pair
    opl_pkg::chan_addr_t base_chan;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= opl_pkg::seq_idle;
            slot_cnt <= '0;
        end else begin
            case (state)
                opl_pkg::seq_idle: begin
                    if (sample_clk_en) begin
                        state    <= opl_pkg::seq_run;
                        slot_cnt <= '0;
                    end
                end
                opl_pkg::seq_run: begin
                    if (slot_cnt == 6'(opl_pkg::num_slot_states - 2)) begin
                        state <= opl_pkg::seq_idle; // last slot issued
                    end else begin
                        slot_cnt <= slot_cnt + 1'b1;
                    end
                end
                default: state <= opl_pkg::seq_idle;
            endcase
        end
    end

    assign slot_valid = (state == opl_pkg::seq_run);
    assign slot_bank  = (slot_cnt >= 6'(opl_pkg::ops_per_bank));
    assign slot_op    = slot_bank ? opl_pkg::op_num_t'(slot_cnt - 6'(opl_pkg::ops_per_bank))
                                  : opl_pkg::op_num_t'(slot_cnt);

    always_comb begin
        op_mod3   = 2'(slot_op % 5'd3);
        op_div6   = 2'(slot_op / 5'd6);
        op_div3   = 3'(slot_op / 5'd3);
        pair_idx  = {1'b0, op_mod3} + (slot_bank ? 3'd3 : 3'd0);
        pair_sel  = connection_sel[pair_idx];
        is_mid    = (slot_op >= 5'd6) && (slot_op < 5'd12);
        base_chan = opl_pkg::chan_addr_t'(op_mod3) + opl_pkg::chan_addr_t'(op_div6) * 4'd3;

        if (slot_op < 5'd6) begin
            op_addr = slot_op;
        end else if (slot_op < 5'd12) begin
            op_addr = slot_op + 5'd2;
        end else begin
            op_addr = slot_op + 5'd4;
        end

        cnt_chan = base_chan;
        kon_chan = (is_mid && pair_sel) ? opl_pkg::chan_addr_t'(op_mod3) : base_chan;

        // odd groups take the slot three back, group 2 only when paired
        mod_eligible = op_div3[0] || (op_div3 == 3'd2 && pair_sel);
    end
endmodule

/* source/opl_reg_file.sv */
// keeps only tl, key-on and connection and silently drops writes to any other register
`timescale 1ns/1ps

module opl_reg_file (
    input  logic                clk,
    input  logic                arst_n,
    reg_wr_if.sink              wr,
    input  logic                rd_en,
    input  opl_pkg::bank_t      rd_bank,
    input  opl_pkg::op_addr_t   op_addr,
    input  opl_pkg::chan_addr_t kon_chan,
    input  opl_pkg::chan_addr_t cnt_chan,
    output opl_pkg::tl_t        tl,
    output logic                kon,
    output logic                cnt
);
    opl_pkg::tl_t tl_mem [opl_pkg::num_banks][opl_pkg::op_slot_depth];
    logic         kon_mem [opl_pkg::num_banks][opl_pkg::chan_depth];
    logic         cnt_mem [opl_pkg::num_banks][opl_pkg::chan_depth];

    opl_pkg::reg_addr_t tl_off;
    opl_pkg::reg_addr_t kon_off;
    opl_pkg::reg_addr_t cnt_off;
    logic               tl_hit;
    logic               kon_hit;
    logic               cnt_hit;

    assign tl_off  = wr.addr - opl_pkg::tl_base;
    assign kon_off = wr.addr - opl_pkg::kon_base;
    assign cnt_off = wr.addr - opl_pkg::cnt_base;

    // offsets wrap below the base so one compare per range is enough
    assign tl_hit  = wr.valid && (tl_off < opl_pkg::reg_addr_t'(opl_pkg::op_slot_depth));
    assign kon_hit = wr.valid && (kon_off < opl_pkg::reg_addr_t'(opl_pkg::chan_depth));
    assign cnt_hit = wr.valid && (cnt_off < opl_pkg::reg_addr_t'(opl_pkg::chan_depth));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int b = 0; b < opl_pkg::num_banks; b++) begin
                for (int i = 0; i < opl_pkg::op_slot_depth; i++) begin
                    tl_mem[b][i] <= '0;
                end
                for (int c = 0; c < opl_pkg::chan_depth; c++) begin
                    kon_mem[b][c] <= 1'b0;
                    cnt_mem[b][c] <= 1'b0;
                end
            end
        end else begin
            if (tl_hit) begin
                tl_mem[wr.bank][opl_pkg::op_addr_t'(tl_off)] <= opl_pkg::tl_t'(wr.data); // ksl bits dropped
            end
            if (kon_hit) begin
                kon_mem[wr.bank][opl_pkg::chan_addr_t'(kon_off)] <= wr.data[5];
            end
            if (cnt_hit) begin
                cnt_mem[wr.bank][opl_pkg::chan_addr_t'(cnt_off)] <= wr.data[0]; // fb bits dropped
            end
        end
    end

    // registered read, data belongs to the slot issued one cycle earlier
    always_ff @(posedge clk) begin
        if (rd_en) begin
            tl  <= tl_mem[rd_bank][op_addr];
            kon <= kon_mem[rd_bank][kon_chan];
            cnt <= cnt_mem[rd_bank][cnt_chan];
        end
    end
endmodule

/* source/reg_write_port.sv */
// host must hold bank, addr and data stable while wr_req is high and wait for wr_ack to fall
`timescale 1ns/1ps

module reg_write_port (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               wr_req,
    input  opl_pkg::bank_t     wr_bank,
    input  opl_pkg::reg_addr_t wr_addr,
    input  opl_pkg::reg_data_t wr_data,
    output logic               wr_ack,
    reg_wr_if.source           wr
);
    opl_pkg::wr_state_e state;
    opl_pkg::wr_state_e next_state;
    opl_pkg::bank_t     bank_q;
    opl_pkg::reg_addr_t addr_q;
    opl_pkg::reg_data_t data_q;

    always_comb begin
        next_state = state;
        case (state)
            opl_pkg::wr_idle:     if (wr_req) next_state = opl_pkg::wr_strobe;
            opl_pkg::wr_strobe:   next_state = opl_pkg::wr_ack_hold; // single write cycle
            opl_pkg::wr_ack_hold: if (!wr_req) next_state = opl_pkg::wr_idle;
            default:              next_state = opl_pkg::wr_idle;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= opl_pkg::wr_idle;
            wr_ack <= 1'b0;
        end else begin
            state  <= next_state;
            wr_ack <= (next_state == opl_pkg::wr_ack_hold); // drops the cycle after req falls
        end
    end

    always_ff @(posedge clk) begin
        if (state == opl_pkg::wr_idle && wr_req) begin // capture on request
            bank_q <= wr_bank;
            addr_q <= wr_addr;
            data_q <= wr_data;
        end
    end

    assign wr.valid = (state == opl_pkg::wr_strobe);
    assign wr.bank  = bank_q;
    assign wr.addr  = addr_q;
    assign wr.data  = data_q;
endmodule

/* source/reg_wr_if.sv */
// carries one accepted register write and valid is high for exactly one cycle per write
`timescale 1ns/1ps

interface reg_wr_if;
    logic               valid; // one-cycle write strobe
    opl_pkg::bank_t     bank;
    opl_pkg::reg_addr_t addr;
    opl_pkg::reg_data_t data;

    modport source (
        output valid,
        output bank,
        output addr,
        output data
    );

    modport sink (
        input valid,
        input bank,
        input addr,
        input data
    );
endinterface

/* source/opl_pkg.sv */
// constants follow the fixed OPL3 slot map and are not meant to be overridden per instance
package opl_pkg;

    localparam int num_banks = 2;
    localparam int ops_per_bank = 18;
    localparam int num_slot_states = num_banks * ops_per_bank + 1; // 36 slots plus idle
    localparam int op_pipe_depth = 6;                              // operator latency in cycles
    localparam int op_slot_depth = 'h16;                           // operator addresses incl. gaps
    localparam int chan_depth = 9;                                 // channels per bank

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic bank_t;
    typedef logic [4:0] op_num_t;    // 0 to 17
    typedef logic [4:0] op_addr_t;   // register offset with the OPL gaps
    typedef logic [3:0] chan_addr_t;
    typedef logic [5:0] tl_t;
    typedef logic signed [12:0] op_out_t;

    localparam reg_addr_t tl_base = 8'h40;  // total level 0x40..0x55
    localparam reg_addr_t kon_base = 8'hB0; // key-on in bit 5
    localparam reg_addr_t cnt_base = 8'hC0; // connection in bit 0

    // slot index lives in a separate counter
    typedef enum logic [5:0] {
        seq_idle = 6'd0,
        seq_run  = 6'd1
    } seq_state_e;

    // four-phase register write slave
    typedef enum logic [1:0] {
        wr_idle     = 2'd0,
        wr_strobe   = 2'd1,
        wr_ack_hold = 2'd2
    } wr_state_e;

endpackage
